// File: build.f
verilog/z80_pkg.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/address_latch.sv
verilog/bus_pins.sv
verilog/sequencer.sv
verilog/z80_lite_top.sv
bench/tb_z80_lite.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the core and its testbench with Verilator, then run the simulation.
# The exit status is the simulator's, so a failing run returns nonzero.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_z80_lite -f build.f -o sim_z80_lite
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_z80_lite
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation run ended with status $status"
    exit $status
fi

exit 0

// File: bench/tb_z80_lite.sv
/* Testbench for the Z80-style core. Builds a random program from an LFSR,
   runs it through a reference model and checks every fetch and write on the pins. */
`timescale 1ns/1ps

module tb_z80_lite;

    // DUT pins
    logic        clk    = 1'b0;
    logic        arst_n = 1'b0;
    logic [7:0]  din    = 8'h00;
    logic        n_wait = 1'b1;
    logic [15:0] addr;
    logic [7:0]  dout;
    logic        n_mreq;
    logic        n_rd;
    logic        n_wr;
    logic        n_m1;
    logic        n_halt;

    // Program image and its generator state
    logic [15:0] lfsr = 16'd71;
    logic [7:0]  mem [65536];
    logic [15:0] gen_pc;
    logic [1:0]  wait_plan [1024];

    // Expected pin activity from the reference model
    logic [15:0] exp_fetch_addr [512];
    logic [8:0]  n_fetch;
    logic [15:0] exp_wr_addr [256];
    logic [7:0]  exp_wr_data [256];
    logic [7:0]  n_wr_exp;

    // Memory model state for the open cycle
    logic        in_cyc    = 1'b0;
    logic        done_seen = 1'b0;
    logic [15:0] cyc_addr  = 16'h0000;
    logic        cyc_rd    = 1'b1;
    logic        cyc_wr    = 1'b1;
    logic        cyc_m1    = 1'b1;
    logic [7:0]  cyc_dout  = 8'h00;
    logic [1:0]  wait_left = 2'd0;
    logic [9:0]  wait_idx  = 10'd0;
    logic [8:0]  fetch_idx = 9'd0;
    logic [7:0]  wr_idx    = 8'd0;

    z80_lite_top z80_lite_top_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .din    (din),
        .n_wait (n_wait),
        .addr   (addr),
        .dout   (dout),
        .n_mreq (n_mreq),
        .n_rd   (n_rd),
        .n_wr   (n_wr),
        .n_m1   (n_m1),
        .n_halt (n_halt)
    );

    // 20 ns period
    always #10 clk = ~clk;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, got, expected);
            $display("Simulation failed");
            $fatal(1, "%s", what);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "%s", why);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random source with taps x^16 + x^14 + x^13 + x^11 + 1
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit with the newest bit in bit 0
    task automatic take_bits(input int n, output logic [15:0] val);
        val = 16'h0000;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            val  = {val[14:0], lfsr[0]};
        end
    endtask

    // Code 6 is the unsupported (HL) and maps to A
    task automatic pick_reg(output logic [2:0] idx);
        logic [15:0] r;
        take_bits(3, r);
        idx = (r[2:0] == 3'd6) ? z80_pkg::reg_a : r[2:0];
    endtask

    task automatic put_byte(input logic [7:0] b);
        mem[gen_pc] = b;
        gen_pc      = gen_pc + 16'd1;
    endtask

    // Background pattern that a legal program never fetches
    task automatic fill_memory();
        logic [16:0] a;
        for (a = 17'd0; a < 17'h10000; a = a + 17'd1)
            mem[a[15:0]] = a[7:0] ^ a[15:8] ^ 8'hA5;
    endtask

    task automatic plan_waits();
        logic [15:0] r;
        logic [10:0] k;
        for (k = 11'd0; k < 11'd1024; k = k + 11'd1) begin
            take_bits(2, r);
            wait_plan[k[9:0]] = r[1:0];
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Program generator
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Code lives in 4 KB segments below 0x8000 and each JP opens the next one
    // Store addresses sit at 0x8000 and up so they never hit code
    task automatic build_program();
        logic [15:0] r;
        logic [15:0] target;
        logic [7:0]  n;
        logic [3:0]  seg;
        logic [2:0]  dst;
        logic [2:0]  src;
        gen_pc = z80_pkg::reset_pc;
        seg    = 4'd0;
        for (n = 8'd0; n < 8'd200; n = n + 8'd1) begin
            take_bits(3, r);
            pick_reg(dst);
            pick_reg(src);
            case (r[2:0])
                3'd0: put_byte(z80_pkg::op_nop);
                3'd1: begin
                    // LD r,n
                    put_byte({2'b00, dst, 3'b110});
                    take_bits(8, r);
                    put_byte(r[7:0]);
                end
                3'd2: put_byte({2'b01, dst, src});
                3'd3, 3'd4: begin
                    // ALU op with a register
                    take_bits(3, r);
                    put_byte({2'b10, r[2:0], src});
                end
                3'd5: begin
                    // ALU op with an immediate
                    take_bits(3, r);
                    put_byte({2'b11, r[2:0], 3'b110});
                    take_bits(8, r);
                    put_byte(r[7:0]);
                end
                default: begin
                    if (r[2:0] == 3'd7 && seg < 4'd7) begin
                        seg = seg + 4'd1;
                        take_bits(8, r);
                        target = {seg, 4'h0, r[7:0]};
                        put_byte(z80_pkg::op_jp);
                        put_byte(target[7:0]);
                        put_byte(target[15:8]);
                        gen_pc = target;
                    end else begin
                        take_bits(15, r);
                        target = {1'b1, r[14:0]};
                        put_byte(z80_pkg::op_st_a);
                        put_byte(target[7:0]);
                        put_byte(target[15:8]);
                    end
                end
            endcase
        end
        put_byte(z80_pkg::op_halt);
    endtask

    // Expected ALU result with the new C in bit 8
    function automatic logic [8:0] alu_ref(input logic [2:0] f, input logic [7:0] a,
                                           input logic [7:0] b, input logic c);
        int ai;
        int bi;
        int full;
        ai = int'(a);
        bi = int'(b);
        case (f)
            3'd0:    full = ai + bi;
            3'd1:    full = ai + bi + int'(c);
            3'd3:    full = ai - bi - int'(c);
            // Logic ops never carry
            3'd4:    full = int'(a & b);
            3'd5:    full = int'(a ^ b);
            3'd6:    full = int'(a | b);
            // SUB and CP
            default: full = ai - bi;
        endcase
        // Carry out above 255 or borrow below 0
        return {(full > 255) || (full < 0), full[7:0]};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model that runs the image in order up to HALT
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic run_model();
        logic [7:0]  regs [8];
        logic [15:0] pc;
        logic [7:0]  op;
        logic [8:0]  res;
        logic        carry;
        logic [3:0]  i;
        for (i = 4'd0; i < 4'd8; i = i + 4'd1)
            regs[i[2:0]] = 8'h00;
        pc       = z80_pkg::reset_pc;
        carry    = 1'b0;
        op       = z80_pkg::op_nop;
        n_fetch  = 9'd0;
        n_wr_exp = 8'd0;
        while (op != z80_pkg::op_halt && n_fetch < 9'd500) begin
            exp_fetch_addr[n_fetch] = pc;
            n_fetch = n_fetch + 9'd1;
            op      = mem[pc];
            pc      = pc + 16'd1;
            if (op == z80_pkg::op_jp) begin
                pc = {mem[pc + 16'd1], mem[pc]};
            end else if (op == z80_pkg::op_st_a) begin
                exp_wr_addr[n_wr_exp] = {mem[pc + 16'd1], mem[pc]};
                exp_wr_data[n_wr_exp] = regs[z80_pkg::reg_a];
                n_wr_exp = n_wr_exp + 8'd1;
                pc       = pc + 16'd2;
            end else if (op != z80_pkg::op_halt) begin
                case (op[7:6])
                    2'b00: begin
                        // NOP unless it is LD r,n
                        if (op[2:0] == 3'b110) begin
                            regs[op[5:3]] = mem[pc];
                            pc = pc + 16'd1;
                        end
                    end
                    2'b01: regs[op[5:3]] = regs[op[2:0]];
                    2'b10: res = alu_ref(op[5:3], regs[z80_pkg::reg_a], regs[op[2:0]], carry);
                    default: begin
                        res = alu_ref(op[5:3], regs[z80_pkg::reg_a], mem[pc], carry);
                        pc  = pc + 16'd1;
                    end
                endcase
                if (op[7]) begin
                    carry = res[8];
                    // CP leaves A alone
                    if (op[5:3] != 3'd7)
                        regs[z80_pkg::reg_a] = res[7:0];
                end
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Memory model sampled and driven on the falling edge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (!n_mreq) begin
            if (!in_cyc) begin
                // New memory cycle
                in_cyc    = 1'b1;
                done_seen = 1'b0;
                cyc_addr  = addr;
                cyc_rd    = n_rd;
                cyc_wr    = n_wr;
                cyc_m1    = n_m1;
                cyc_dout  = dout;
                wait_left = wait_plan[wait_idx];
                wait_idx  = wait_idx + 10'd1;
                check_value("one of n_rd and n_wr low", 32'(n_rd ^ n_wr), 32'd1);
                if (!n_m1) begin
                    check_value("n_rd in opcode fetch", 32'(n_rd), 32'd0);
                    if (fetch_idx == n_fetch) begin
                        abort_run("Opcode fetch past the end of the program");
                    end else begin
                        check_value("fetch address", 32'(addr),
                                    32'(exp_fetch_addr[fetch_idx]));
                        fetch_idx = fetch_idx + 9'd1;
                    end
                end
            end else if (done_seen) begin
                abort_run("Strobes stayed low after n_wait went high");
            end else begin
                // Wait state where everything must hold
                check_value("addr during wait", 32'(addr), 32'(cyc_addr));
                check_value("n_rd during wait", 32'(n_rd), 32'(cyc_rd));
                check_value("n_wr during wait", 32'(n_wr), 32'(cyc_wr));
                check_value("n_m1 during wait", 32'(n_m1), 32'(cyc_m1));
                if (!n_wr)
                    check_value("dout during wait", 32'(dout), 32'(cyc_dout));
            end
            if (!n_rd)
                din <= mem[addr];
            if (wait_left == 2'd0) begin
                // Ready so the access completes on the next rising edge
                n_wait    <= 1'b1;
                done_seen = 1'b1;
                if (!n_wr) begin
                    if (wr_idx == n_wr_exp) begin
                        abort_run("Write cycle with no matching store in the program");
                    end else begin
                        check_value("write address", 32'(addr), 32'(exp_wr_addr[wr_idx]));
                        check_value("write data", 32'(dout), 32'(exp_wr_data[wr_idx]));
                        wr_idx = wr_idx + 8'd1;
                    end
                end
            end else begin
                n_wait    <= 1'b0;
                wait_left = wait_left - 2'd1;
            end
        end else begin
            if (in_cyc && !done_seen)
                abort_run("Strobes rose while n_wait was low");
            in_cyc = 1'b0;
            n_wait <= 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int edges;
        int cnt;
        fill_memory();
        build_program();
        plan_waits();
        run_model();

        // Reset for 3 cycles with all strobes idle
        repeat (3) @(negedge clk);
        check_value("n_mreq in reset", 32'(n_mreq), 32'd1);
        check_value("n_rd in reset", 32'(n_rd), 32'd1);
        check_value("n_wr in reset", 32'(n_wr), 32'd1);
        check_value("n_m1 in reset", 32'(n_m1), 32'd1);
        check_value("n_halt in reset", 32'(n_halt), 32'd1);
        arst_n = 1'b1;

        // First fetch on the second rising edge
        edges = 0;
        while (n_mreq && edges < 8) begin
            @(negedge clk);
            edges++;
        end
        if (n_mreq)
            abort_run("No fetch started after reset");
        check_value("edges to first fetch", edges, 32'd2);
        check_value("first fetch address", 32'(addr), 32'(z80_pkg::reset_pc));

        cnt = 0;
        while (n_halt && cnt < 20000) begin
            @(negedge clk);
            cnt++;
        end
        if (n_halt)
            abort_run("Timed out waiting for n_halt");

        // Core stays quiet once halted
        repeat (50) begin
            @(negedge clk);
            check_value("n_mreq after HALT", 32'(n_mreq), 32'd1);
            check_value("n_rd after HALT", 32'(n_rd), 32'd1);
            check_value("n_wr after HALT", 32'(n_wr), 32'd1);
            check_value("n_m1 after HALT", 32'(n_m1), 32'd1);
            check_value("n_halt after HALT", 32'(n_halt), 32'd0);
        end

        if (fetch_idx != n_fetch || wr_idx != n_wr_exp) begin
            abort_run("Core halted before every expected fetch and write was seen");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// File: verilog/z80_lite_top.sv
/* Top level of the small Z80-style core. Joins the internal data bus mux,
   the sequencer and the datapath blocks, and brings out the memory pin bus. */
`timescale 1ns/1ps

module z80_lite_top (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [7:0]  din,
    input  logic        n_wait,
    output logic [15:0] addr,
    output logic [7:0]  dout,
    output logic        n_mreq,
    output logic        n_rd,
    output logic        n_wr,
    output logic        n_m1,
    output logic        n_halt
);

    // Internal data bus and its sources
    logic [7:0] db;
    logic [7:0] rdata;
    logic [7:0] alu_result;
    logic [7:0] reg_q;
    logic [7:0] acc;

    // Control from the sequencer
    logic                 cyc_start;
    logic                 cyc_done;
    z80_pkg::cycle_t      cyc_kind;
    z80_pkg::addr_sel_t   addr_sel;
    z80_pkg::bus_src_t    bus_src;
    z80_pkg::reg_idx_t    reg_waddr;
    z80_pkg::reg_idx_t    reg_raddr;
    z80_pkg::alu_op_t     alu_op;
    logic                 pc_inc;
    logic                 pc_load;
    logic                 reg_we;
    logic                 acc_we;
    logic                 flag_we;
    logic                 lo_we;
    logic                 hi_we;
    logic                 halted;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Internal data bus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (bus_src)
            z80_pkg::src_alu:  db = alu_result;
            z80_pkg::src_regs: db = reg_q;
            default:           db = rdata;
        endcase
    end

    // Control block
    sequencer     sequencer     ( .* );

    // Datapath blocks around the bus
    alu           alu           ( .*, .operand(db) );
    reg_file      reg_file      ( .*, .wdata(db) );
    address_latch address_latch ( .* );
    bus_pins      bus_pins      ( .*, .wdata(db) );

endmodule

// File: verilog/sequencer.sv
/* Control block of the core: instruction register, opcode decode and the
   machine-cycle state machine that steers every write enable on the bus. */
`timescale 1ns/1ps

module sequencer (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [7:0]         db,
    input  logic               cyc_done,
    output logic               cyc_start,
    output z80_pkg::cycle_t    cyc_kind,
    output z80_pkg::addr_sel_t addr_sel,
    output logic               pc_inc,
    output logic               pc_load,
    output z80_pkg::bus_src_t  bus_src,
    output logic               reg_we,
    output z80_pkg::reg_idx_t  reg_waddr,
    output z80_pkg::reg_idx_t  reg_raddr,
    output z80_pkg::alu_op_t   alu_op,
    output logic               acc_we,
    output logic               flag_we,
    output logic               lo_we,
    output logic               hi_we,
    output logic               halted
);

    logic [7:0]      ir;
    logic            ir_we;
    logic            started;
    logic            busy;
    logic            wb_pending;
    logic [1:0]      opnd_cnt;
    z80_pkg::cycle_t cur_kind;
    z80_pkg::cycle_t next_kind;
    z80_pkg::cycle_t kind_now;
    logic            s_phase;
    logic            exec_s;
    logic            done_fetch;
    logic            done_read;
    logic            wb_cycle;
    logic            is_ld_rn;
    logic            is_ld_rr;
    logic            is_alu_r;
    logic            is_alu_n;
    logic            is_jp;
    logic            is_st;
    logic            is_halt;
    logic            need_nn;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign is_halt  = (ir == z80_pkg::op_halt);
    assign is_jp    = (ir == z80_pkg::op_jp);
    assign is_st    = (ir == z80_pkg::op_st_a);
    // 00 rrr 110
    assign is_ld_rn = (ir[7:6] == 2'b00) && (ir[2:0] == 3'b110);
    // 01 ddd sss, HALT sits in the middle of this block
    assign is_ld_rr = (ir[7:6] == 2'b01) && !is_halt;
    // 10 ooo sss and 11 ooo 110
    assign is_alu_r = (ir[7:6] == 2'b10);
    assign is_alu_n = (ir[7:6] == 2'b11) && (ir[2:0] == 3'b110);
    // Two operand bytes nn
    assign need_nn  = is_jp | is_st;

    assign alu_op = z80_pkg::alu_op_t'(ir[5:3]);

    // Start phase of a machine cycle, also the decode or execute slot
    assign s_phase    = started & ~busy;
    assign exec_s     = s_phase & (cur_kind == z80_pkg::cyc_fetch);
    assign done_fetch = busy & cyc_done & (cur_kind == z80_pkg::cyc_fetch);
    assign done_read  = busy & cyc_done & (cur_kind == z80_pkg::cyc_read);
    // ALU result goes back to A while the pins are busy
    assign wb_cycle   = wb_pending & busy & ~cyc_done;

    // Kind of the cycle that follows the one just finished
    always_comb begin
        case (cur_kind)
            z80_pkg::cyc_fetch: begin
                if (is_halt)
                    next_kind = z80_pkg::cyc_halt;
                else if (is_ld_rn || is_alu_n || need_nn)
                    next_kind = z80_pkg::cyc_read;
                else
                    next_kind = z80_pkg::cyc_fetch;
            end
            z80_pkg::cyc_read: begin
                if (need_nn && opnd_cnt == 2'd1)
                    next_kind = z80_pkg::cyc_read;
                else if (is_st && opnd_cnt == 2'd2)
                    next_kind = z80_pkg::cyc_write;
                else
                    next_kind = z80_pkg::cyc_fetch;
            end
            z80_pkg::cyc_write: next_kind = z80_pkg::cyc_fetch;
            default:            next_kind = z80_pkg::cyc_halt;
        endcase
    end

    assign kind_now  = busy ? cur_kind : next_kind;
    assign cyc_kind  = kind_now;
    assign addr_sel  = (kind_now == z80_pkg::cyc_write) ? z80_pkg::sel_latch : z80_pkg::sel_pc;
    assign cyc_start = s_phase & (next_kind != z80_pkg::cyc_halt);
    assign halted    = (cur_kind == z80_pkg::cyc_halt);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus steering and write enables
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        bus_src   = z80_pkg::src_pins;
        reg_we    = 1'b0;
        reg_waddr = ir[5:3];
        reg_raddr = ir[2:0];
        acc_we    = 1'b0;
        flag_we   = 1'b0;
        lo_we     = 1'b0;
        hi_we     = 1'b0;
        pc_inc    = 1'b0;
        pc_load   = 1'b0;
        ir_we     = 1'b0;
        // Opcode byte lands in IR
        if (done_fetch) begin
            ir_we  = 1'b1;
            pc_inc = 1'b1;
        end
        // Operand byte straight from the pins
        if (done_read) begin
            reg_we  = is_ld_rn;
            flag_we = is_alu_n;
            acc_we  = is_alu_n && (alu_op != z80_pkg::alu_cp);
            lo_we   = need_nn && (opnd_cnt == 2'd0);
            hi_we   = need_nn && (opnd_cnt == 2'd1);
            pc_load = is_jp && (opnd_cnt == 2'd1);
            pc_inc  = !pc_load;
        end
        // Register operand ops run in the slot after the fetch
        if (exec_s && (is_ld_rr || is_alu_r)) begin
            bus_src = z80_pkg::src_regs;
            reg_we  = is_ld_rr;
            flag_we = is_alu_r;
            acc_we  = is_alu_r && (alu_op != z80_pkg::alu_cp);
        end
        // A onto the bus for the pin block to hold as write data
        if (s_phase && next_kind == z80_pkg::cyc_write) begin
            bus_src   = z80_pkg::src_regs;
            reg_raddr = z80_pkg::reg_a;
        end
        if (wb_cycle) begin
            bus_src   = z80_pkg::src_alu;
            reg_we    = 1'b1;
            reg_waddr = z80_pkg::reg_a;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            started    <= 1'b0;
            busy       <= 1'b0;
            cur_kind   <= z80_pkg::cyc_fetch;
            ir         <= z80_pkg::op_nop;
            opnd_cnt   <= 2'd0;
            wb_pending <= 1'b0;
        end else begin
            // One idle cycle after reset before the first fetch
            started <= 1'b1;
            if (s_phase) begin
                cur_kind <= next_kind;
                busy     <= cyc_start;
            end else if (busy && cyc_done) begin
                busy <= 1'b0;
            end
            if (ir_we) begin
                ir       <= db;
                opnd_cnt <= 2'd0;
            end else if (done_read) begin
                opnd_cnt <= opnd_cnt + 2'd1;
            end
            if (acc_we)
                wb_pending <= 1'b1;
            else if (wb_cycle)
                wb_pending <= 1'b0;
        end
    end

endmodule

// File: verilog/bus_pins.sv
/* Pin control for memory cycles. Drops the strobes one edge after cyc_start,
   holds them through wait states and returns read data with cyc_done. */
`timescale 1ns/1ps

module bus_pins (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            cyc_start,
    input  z80_pkg::cycle_t cyc_kind,
    input  logic            halted,
    input  logic [7:0]      din,
    input  logic            n_wait,
    input  logic [7:0]      wdata,
    output logic [7:0]      rdata,
    output logic            cyc_done,
    output logic [7:0]      dout,
    output logic            n_mreq,
    output logic            n_rd,
    output logic            n_wr,
    output logic            n_m1,
    output logic            n_halt
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Strobe state, n_mreq low means a cycle is open
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            n_mreq   <= 1'b1;
            n_rd     <= 1'b1;
            n_wr     <= 1'b1;
            n_m1     <= 1'b1;
            n_halt   <= 1'b1;
            cyc_done <= 1'b0;
        end else begin
            n_halt   <= ~halted;
            cyc_done <= 1'b0;
            if (cyc_start) begin
                n_mreq <= 1'b0;
                n_rd   <= (cyc_kind == z80_pkg::cyc_write);
                n_wr   <= (cyc_kind != z80_pkg::cyc_write);
                n_m1   <= (cyc_kind != z80_pkg::cyc_fetch);
            end else if (!n_mreq && n_wait) begin
                // Memory ready, close the cycle
                n_mreq   <= 1'b1;
                n_rd     <= 1'b1;
                n_wr     <= 1'b1;
                n_m1     <= 1'b1;
                cyc_done <= 1'b1;
            end
        end
    end

    // Write data held from the strobe edge, read data taken at the ready edge
    always_ff @(posedge clk) begin
        if (cyc_start && cyc_kind == z80_pkg::cyc_write)
            dout <= wdata;
        if (!n_rd && n_wait)
            rdata <= din;
    end

endmodule

// File: verilog/address_latch.sv
/* Program counter with its incrementer, the nn operand latch and the mux that
   picks which of the two goes out on the address pins. */
`timescale 1ns/1ps

module address_latch (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [7:0]         db,
    input  logic               lo_we,
    input  logic               hi_we,
    input  z80_pkg::addr_sel_t addr_sel,
    input  logic               pc_inc,
    input  logic               pc_load,
    output logic [15:0]        addr
);

    logic [15:0] pc;
    logic [7:0]  lo_q;
    logic [7:0]  hi_q;

    // JP takes the high byte from the bus in the same cycle it is latched
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            pc <= z80_pkg::reset_pc;
        else if (pc_load)
            pc <= {db, lo_q};
        else if (pc_inc)
            pc <= pc + 16'd1;
    end

    // Operand latch, one byte per read
    always_ff @(posedge clk) begin
        if (lo_we)
            lo_q <= db;
        if (hi_we)
            hi_q <= db;
    end

    assign addr = (addr_sel == z80_pkg::sel_latch) ? {hi_q, lo_q} : pc;

endmodule

// File: verilog/reg_file.sv
/* Register file with B, C, D, E, H, L and A. One write port at the clock edge,
   one combinational read port and a direct accumulator output for the ALU. */
`timescale 1ns/1ps

module reg_file (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              reg_we,
    input  z80_pkg::reg_idx_t reg_waddr,
    input  z80_pkg::reg_idx_t reg_raddr,
    input  logic [7:0]        wdata,
    output logic [7:0]        reg_q,
    output logic [7:0]        acc
);

    logic [7:0] regs [7];

    // Code 7 (A) folds onto slot 6, the (HL) hole
    function automatic logic [2:0] slot(input z80_pkg::reg_idx_t idx);
        return (idx == z80_pkg::reg_a) ? 3'd6 : idx;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 7; i++)
                regs[i] <= 8'h00;
        end else if (reg_we && reg_waddr != 3'd6) begin
            regs[slot(reg_waddr)] <= wdata;
        end
    end

    assign reg_q = regs[slot(reg_raddr)];
    assign acc   = regs[slot(z80_pkg::reg_a)];

endmodule

// File: verilog/alu.sv
/* 8-bit ALU working on A and the bus operand. Holds the result latch that is
   written back to A over the bus, and the carry flag that ADC and SBC use. */
`timescale 1ns/1ps

module alu (
    input  logic             clk,
    input  logic             arst_n,
    input  z80_pkg::alu_op_t alu_op,
    input  logic [7:0]       operand,
    input  logic             acc_we,
    input  logic             flag_we,
    input  logic [7:0]       acc,
    output logic [7:0]       alu_result
);

    logic [8:0] sum;
    logic       flag_c;

    // Bit 8 is carry for adds and borrow for subtracts
    always_comb begin
        case (alu_op)
            z80_pkg::alu_add: sum = {1'b0, acc} + {1'b0, operand};
            z80_pkg::alu_adc: sum = {1'b0, acc} + {1'b0, operand} + {8'h00, flag_c};
            z80_pkg::alu_sbc: sum = {1'b0, acc} - {1'b0, operand} - {8'h00, flag_c};
            // Logic ops clear C
            z80_pkg::alu_and: sum = {1'b0, acc & operand};
            z80_pkg::alu_xor: sum = {1'b0, acc ^ operand};
            z80_pkg::alu_or:  sum = {1'b0, acc | operand};
            // SUB and CP
            default:          sum = {1'b0, acc} - {1'b0, operand};
        endcase
    end

    // Stored carry for ADC and SBC
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            flag_c <= 1'b0;
        else if (flag_we)
            flag_c <= sum[8];
    end

    // Result latch that feeds the bus on write-back
    always_ff @(posedge clk) begin
        if (acc_we)
            alu_result <= sum[7:0];
    end

endmodule

// File: verilog/z80_pkg.sv
/* Shared definitions for the Z80-style core: opcode fields, ALU operation codes,
   register indices, machine-cycle kinds and internal bus selects.
   Blocks refer to these by scoped name. */
package z80_pkg;

    // ALU operation, opcode bits 5..3 in Z80 order
    typedef enum logic [2:0] {
        alu_add = 3'd0,
        alu_adc = 3'd1,
        alu_sub = 3'd2,
        alu_sbc = 3'd3,
        alu_and = 3'd4,
        alu_xor = 3'd5,
        alu_or  = 3'd6,
        alu_cp  = 3'd7
    } alu_op_t;

    // Register index, B=0 C=1 D=2 E=3 H=4 L=5 A=7
    typedef logic [2:0] reg_idx_t;
    localparam reg_idx_t reg_a = 3'd7;

    // Machine-cycle kind
    typedef enum logic [1:0] {
        cyc_fetch = 2'd0,
        cyc_read  = 2'd1,
        cyc_write = 2'd2,
        cyc_halt  = 2'd3
    } cycle_t;

    // Address source toward the pins
    typedef enum logic {
        sel_pc    = 1'b0,
        sel_latch = 1'b1
    } addr_sel_t;

    // Internal data bus driver
    typedef enum logic [2:0] {
        src_pins = 3'd0,
        src_alu  = 3'd1,
        src_regs = 3'd2,
        src_lo   = 3'd3,
        src_hi   = 3'd4
    } bus_src_t;

    // Fixed opcodes
    localparam logic [7:0] op_nop  = 8'h00;
    localparam logic [7:0] op_halt = 8'h76;
    localparam logic [7:0] op_jp   = 8'hC3;
    localparam logic [7:0] op_st_a = 8'h32;

    localparam logic [15:0] reset_pc = 16'h0000;

endpackage
